// ==== aes_pkg.sv ====
package aes_pkg;

    // basic widths
    typedef logic [7:0]   byte_t;
    typedef logic [31:0]  word_t;
    typedef logic [127:0] block_t;
    typedef logic [255:0] key_t;
    typedef logic [3:0]   rk_addr_t;
    typedef logic [1:0]   mode_t;

    // host request codes, 3 is reserved
    localparam mode_t MODE_ENC = 2'd0;
    localparam mode_t MODE_DEC = 2'd1;
    localparam mode_t MODE_KEY = 2'd2;

    // aes-256 round structure
    localparam int NUM_ROUNDS     = 14;
    localparam int NUM_ROUND_KEYS = 15;
    localparam int RK_DEPTH       = 16;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add multiply in gf(2^8)
    function automatic byte_t gf_mul(input byte_t a, input byte_t b);
        byte_t acc;
        byte_t p;
        acc = 8'h00;
        p   = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = xtime(p);
        end
        return acc;
    endfunction

    // a^254 is the inverse, zero maps to zero
    function automatic byte_t gf_inv(input byte_t a);
        byte_t sq;
        byte_t acc;
        sq  = a;
        acc = 8'h01;
        // collect a^2 * a^4 * ... * a^128
        for (int i = 1; i < 8; i++)
        begin
            sq  = gf_mul(sq, sq);
            acc = gf_mul(acc, sq);
        end
        return acc;
    endfunction

    // forward s-box: inverse, then affine map
    function automatic byte_t sub_byte(input byte_t b);
        byte_t x;
        x = gf_inv(b);
        return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]}
                 ^ {x[3:0], x[7:4]} ^ 8'h63;
    endfunction

    // inverse s-box: inverse affine map, then inverse
    function automatic byte_t inv_sub_byte(input byte_t s);
        byte_t x;
        x = {s[6:0], s[7]} ^ {s[4:0], s[7:5]} ^ {s[1:0], s[7:2]} ^ 8'h05;
        return gf_inv(x);
    endfunction

    // one column, coefficients 2 3 1 1
    function automatic word_t mix_column(input word_t w);
        byte_t a [4];
        word_t r;
        for (int i = 0; i < 4; i++)
            a[i] = w[31-8*i -: 8];
        for (int i = 0; i < 4; i++)
            r[31-8*i -: 8] = xtime(a[i]) ^ xtime(a[(i+1)%4]) ^ a[(i+1)%4]
                             ^ a[(i+2)%4] ^ a[(i+3)%4];
        return r;
    endfunction

    // one column, coefficients 14 11 13 9
    function automatic word_t inv_mix_column(input word_t w);
        byte_t a [4];
        word_t r;
        for (int i = 0; i < 4; i++)
            a[i] = w[31-8*i -: 8];
        for (int i = 0; i < 4; i++)
            r[31-8*i -: 8] = gf_mul(a[i], 8'h0e) ^ gf_mul(a[(i+1)%4], 8'h0b)
                             ^ gf_mul(a[(i+2)%4], 8'h0d) ^ gf_mul(a[(i+3)%4], 8'h09);
        return r;
    endfunction

    // round constant for schedule step 1..7
    function automatic byte_t rcon(input logic [2:0] step);
        return 8'h01 << (step - 3'd1);
    endfunction

endpackage

// ==== aes_key_expand.sv ====
`timescale 1ns/1ps

module aes_key_expand (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  aes_pkg::key_t     key,
    output aes_pkg::block_t   round_key,
    output aes_pkg::rk_addr_t rk_index,
    output logic              rk_valid,
    output logic              done
);

    // window of eight words: round key k and k+1
    aes_pkg::block_t win_old;
    aes_pkg::block_t win_new;
    aes_pkg::word_t  temp;
    aes_pkg::block_t expanded;

    function automatic aes_pkg::word_t sub_word(input aes_pkg::word_t w);
        return {aes_pkg::sub_byte(w[31:24]), aes_pkg::sub_byte(w[23:16]),
                aes_pkg::sub_byte(w[15:8]), aes_pkg::sub_byte(w[7:0])};
    endfunction

    // round key k+2 from k and k+1
    always_comb
    begin
        // k+2 even: rotword, subword and rcon on the last word
        if (!rk_index[0])
            temp = sub_word({win_new[23:0], win_new[31:24]})
                   ^ {aes_pkg::rcon(rk_index[3:1] + 3'd1), 24'h000000};
        // odd: subword only
        else
            temp = sub_word(win_new[31:0]);
        expanded[127:96] = win_old[127:96] ^ temp;
        expanded[95:64]  = win_old[95:64]  ^ expanded[127:96];
        expanded[63:32]  = win_old[63:32]  ^ expanded[95:64];
        expanded[31:0]   = win_old[31:0]   ^ expanded[63:32];
    end

    // sequencing, one round key per cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rk_valid <= 1'b0;
            rk_index <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                rk_valid <= 1'b1;
                rk_index <= '0;
            end
            else if (rk_valid)
            begin
                // last key goes out this cycle
                if (rk_index == aes_pkg::rk_addr_t'(aes_pkg::NUM_ROUND_KEYS - 1))
                begin
                    rk_valid <= 1'b0;
                    done     <= 1'b1;
                end
                else
                begin
                    rk_index <= rk_index + 1'b1;
                end
            end
        end
    end

    // key halves are round keys 0 and 1
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            win_old <= key[255:128];
            win_new <= key[127:0];
        end
        else if (rk_valid)
        begin
            win_old <= win_new;
            win_new <= expanded;
        end
    end

    assign round_key = win_old;

endmodule

// ==== aes_round_key_store.sv ====
`timescale 1ns/1ps

module aes_round_key_store (
    input  logic              clk,
    input  logic              resetn,
    input  logic              wr_en,
    input  aes_pkg::rk_addr_t wr_addr,
    input  aes_pkg::block_t   wr_data,
    input  aes_pkg::rk_addr_t rd_addr,
    output aes_pkg::block_t   rd_data
);

    // round keys 0..14, top entry spare
    aes_pkg::block_t mem [aes_pkg::RK_DEPTH];

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rd_data <= '0;
        else
            rd_data <= mem[rd_addr];
    end

endmodule

// ==== aes_encrypt_core.sv ====
`timescale 1ns/1ps

module aes_encrypt_core (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  aes_pkg::block_t   data_in,
    output aes_pkg::rk_addr_t key_addr,
    input  aes_pkg::block_t   round_key,
    output aes_pkg::block_t   data_out,
    output logic              done
);

    aes_pkg::block_t state;
    aes_pkg::block_t sb_sr;
    aes_pkg::block_t mixed;
    aes_pkg::block_t state_next;
    logic [3:0]      step;
    logic            running;

    // subbytes and shiftrows together, column-major bytes
    function automatic aes_pkg::block_t sub_shift(input aes_pkg::block_t s);
        aes_pkg::block_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[127-32*c-8*row -: 8] =
                    aes_pkg::sub_byte(s[127-32*((c+row)%4)-8*row -: 8]);
        return r;
    endfunction

    always_comb
    begin
        sb_sr = sub_shift(state);
        for (int c = 0; c < 4; c++)
            mixed[127-32*c -: 32] = aes_pkg::mix_column(sb_sr[127-32*c -: 32]);
        // step 1 is the initial add-round-key
        if (step == 4'd1)
            state_next = state ^ round_key;
        // final round has no mixcolumns
        else if (step == 4'(aes_pkg::NUM_ROUNDS + 1))
            state_next = sb_sr ^ round_key;
        else
            state_next = mixed ^ round_key;
    end

    // step 0 waits for the first key read
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            running  <= 1'b0;
            step     <= '0;
            key_addr <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running  <= 1'b1;
                step     <= '0;
                key_addr <= '0;
            end
            else if (running)
            begin
                step <= step + 1'b1;
                if (key_addr != aes_pkg::rk_addr_t'(aes_pkg::NUM_ROUNDS))
                    key_addr <= key_addr + 1'b1;
                if (step == 4'(aes_pkg::NUM_ROUNDS + 1))
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            state <= data_in;
        else if (running && step != 4'd0)
            state <= state_next;
    end

    // result stays until next start
    assign data_out = state;

endmodule

// ==== aes_decrypt_core.sv ====
`timescale 1ns/1ps

module aes_decrypt_core (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  aes_pkg::block_t   data_in,
    output aes_pkg::rk_addr_t key_addr,
    input  aes_pkg::block_t   round_key,
    output aes_pkg::block_t   data_out,
    output logic              done
);

    aes_pkg::block_t state;
    aes_pkg::block_t keyed;
    aes_pkg::block_t unmixed;
    aes_pkg::block_t state_next;
    logic [3:0]      step;
    logic            running;

    // invshiftrows and invsubbytes, row r moves right by r
    function automatic aes_pkg::block_t inv_sub_shift(input aes_pkg::block_t s);
        aes_pkg::block_t r;
        for (int c = 0; c < 4; c++)
            for (int row = 0; row < 4; row++)
                r[127-32*c-8*row -: 8] =
                    aes_pkg::inv_sub_byte(s[127-32*((c-row+4)%4)-8*row -: 8]);
        return r;
    endfunction

    always_comb
    begin
        keyed = inv_sub_shift(state) ^ round_key;
        for (int c = 0; c < 4; c++)
            unmixed[127-32*c -: 32] = aes_pkg::inv_mix_column(keyed[127-32*c -: 32]);
        // first step uses key 14 alone
        if (step == 4'd1)
            state_next = state ^ round_key;
        // key 0 step skips invmixcolumns
        else if (step == 4'(aes_pkg::NUM_ROUNDS + 1))
            state_next = keyed;
        else
            state_next = unmixed;
    end

    // keys walk down from 14, same timing as the encrypter
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            running  <= 1'b0;
            step     <= '0;
            key_addr <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                running  <= 1'b1;
                step     <= '0;
                key_addr <= aes_pkg::rk_addr_t'(aes_pkg::NUM_ROUNDS);
            end
            else if (running)
            begin
                step <= step + 1'b1;
                if (key_addr != '0)
                    key_addr <= key_addr - 1'b1;
                if (step == 4'(aes_pkg::NUM_ROUNDS + 1))
                begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            state <= data_in;
        else if (running && step != 4'd0)
            state <= state_next;
    end

    assign data_out = state;

endmodule

// ==== aes256_device.sv ====
`timescale 1ns/1ps

module aes256_device (
    input  logic            clk,
    input  logic            resetn,
    input  aes_pkg::block_t inp_device,
    input  aes_pkg::mode_t  mod_en,
    input  logic            ctrl_dataIn,
    output aes_pkg::block_t outp_device,
    output logic            ctrl_dataOut,
    output logic            busy
);

    typedef enum logic [2:0] {
        idle,
        key_wait_low,
        key_run,
        enc_run,
        dec_run,
        finish
    } state_t;

    state_t state;
    state_t state_next;

    // captured request payload
    aes_pkg::block_t data_q;
    aes_pkg::block_t key_hi;

    logic              kexp_start;
    logic              enc_start;
    logic              dec_start;
    aes_pkg::block_t   kexp_round_key;
    aes_pkg::rk_addr_t kexp_index;
    logic              kexp_valid;
    logic              kexp_done;
    aes_pkg::rk_addr_t enc_key_addr;
    aes_pkg::rk_addr_t dec_key_addr;
    aes_pkg::rk_addr_t rd_addr;
    aes_pkg::block_t   rd_key;
    aes_pkg::block_t   enc_data_out;
    aes_pkg::block_t   dec_data_out;
    logic              enc_done;
    logic              dec_done;

    // finish does not block, a strobe there is taken like in idle
    assign busy         = (state == key_run) || (state == enc_run) || (state == dec_run);
    assign ctrl_dataOut = (state == finish);

    always_comb
    begin
        state_next = state;
        if (state == finish)
            state_next = idle;
        case (state)
            idle, key_wait_low, finish:
            begin
                if (ctrl_dataIn && mod_en == aes_pkg::MODE_KEY)
                    state_next = (state == key_wait_low) ? key_run : key_wait_low;
                // enc or dec drops a pending key half
                else if (ctrl_dataIn && mod_en == aes_pkg::MODE_ENC)
                    state_next = enc_run;
                else if (ctrl_dataIn && mod_en == aes_pkg::MODE_DEC)
                    state_next = dec_run;
            end
            key_run:
            begin
                if (kexp_done)
                    state_next = idle;
            end
            enc_run:
            begin
                if (enc_done)
                    state_next = finish;
            end
            dec_run:
            begin
                if (dec_done)
                    state_next = finish;
            end
            default:
                state_next = idle;
        endcase
    end

    // start pulses on entry into a run state
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state       <= idle;
            kexp_start  <= 1'b0;
            enc_start   <= 1'b0;
            dec_start   <= 1'b0;
            outp_device <= '0;
        end
        else
        begin
            state      <= state_next;
            kexp_start <= (state_next == key_run) && (state != key_run);
            enc_start  <= (state_next == enc_run) && (state != enc_run);
            dec_start  <= (state_next == dec_run) && (state != dec_run);
            // result registered on the way into finish
            if (state_next == finish && state != finish)
                outp_device <= (state == dec_run) ? dec_data_out : enc_data_out;
        end
    end

    // upper key half only on the first key strobe
    always_ff @(posedge clk)
    begin
        if (ctrl_dataIn && !busy)
            data_q <= inp_device;
        if (state_next == key_wait_low && state != key_wait_low)
            key_hi <= inp_device;
    end

    // only the running core drives the read port
    assign rd_addr = (state == dec_run) ? dec_key_addr : enc_key_addr;

    aes_key_expand key_expand0 (
        .clk       (clk),
        .resetn    (resetn),
        .start     (kexp_start),
        .key       ({key_hi, data_q}),
        .round_key (kexp_round_key),
        .rk_index  (kexp_index),
        .rk_valid  (kexp_valid),
        .done      (kexp_done)
    );

    aes_round_key_store key_store0 (
        .clk     (clk),
        .resetn  (resetn),
        .wr_en   (kexp_valid),
        .wr_addr (kexp_index),
        .wr_data (kexp_round_key),
        .rd_addr (rd_addr),
        .rd_data (rd_key)
    );

    aes_encrypt_core encrypt0 (
        .clk       (clk),
        .resetn    (resetn),
        .start     (enc_start),
        .data_in   (data_q),
        .key_addr  (enc_key_addr),
        .round_key (rd_key),
        .data_out  (enc_data_out),
        .done      (enc_done)
    );

    aes_decrypt_core decrypt0 (
        .clk       (clk),
        .resetn    (resetn),
        .start     (dec_start),
        .data_in   (data_q),
        .key_addr  (dec_key_addr),
        .round_key (rd_key),
        .data_out  (dec_data_out),
        .done      (dec_done)
    );

endmodule

// ==== tb_aes256_device.sv ====
`timescale 1ns/1ps

module tb_aes256_device;

    // about 45 requests of ~19 cycles plus three key loads with ample margin
    localparam int TIMEOUT_CYCLES = 4000;
    // strobe sampling edge to ctrl_dataOut edge
    localparam int LATENCY = 18;

    // fips-197 appendix c.3 vectors
    localparam aes_pkg::key_t FIPS_KEY =
        256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
    localparam aes_pkg::block_t FIPS_PT = 128'h00112233445566778899aabbccddeeff;
    localparam aes_pkg::block_t FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic            clk;
    logic            resetn;
    aes_pkg::block_t inp_device;
    aes_pkg::mode_t  mod_en;
    logic            ctrl_dataIn;
    aes_pkg::block_t outp_device;
    logic            ctrl_dataOut;
    logic            busy;

    logic [31:0] rng_state;
    int          cycles = 0;

    aes256_device dut0 (
        .clk          (clk),
        .resetn       (resetn),
        .inp_device   (inp_device),
        .mod_en       (mod_en),
        .ctrl_dataIn  (ctrl_dataIn),
        .outp_device  (outp_device),
        .ctrl_dataOut (ctrl_dataOut),
        .busy         (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog bounding every wait loop below
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES)
        begin
            $display("Errors found");
            $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $fatal(1, "run stopped by the watchdog");
        end
    end

    task automatic check_eq(input logic [127:0] got, input logic [127:0] expected,
                            input string what);
        if (got !== expected)
        begin
            $display("Errors found");
            $display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, got, expected);
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // 32-bit xorshift with shifts 13 17 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic random_block(output aes_pkg::block_t b);
        for (int i = 0; i < 4; i++)
        begin
            rng_state = xorshift32(rng_state);
            b[127-32*i -: 32] = rng_state;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        while (busy)
            wait_cycle();
    endtask

    // two key strobes back to back with the upper half first
    task automatic load_key(input aes_pkg::key_t key);
        wait_idle();
        mod_en      = aes_pkg::MODE_KEY;
        inp_device  = key[255:128];
        ctrl_dataIn = 1'b1;
        wait_cycle();
        // waiting for the low half and still open for strobes
        check_eq({127'd0, busy}, 128'd0, "busy after first key half");
        inp_device = key[127:0];
        wait_cycle();
        ctrl_dataIn = 1'b0;
        check_eq({127'd0, busy}, 128'd1, "busy after second key half");
        // falling busy ends the expansion
        wait_idle();
    endtask

    // one request with its latency checked on every call
    task automatic run_block(input aes_pkg::mode_t mode, input aes_pkg::block_t data,
                             output aes_pkg::block_t result);
        int edges;
        wait_idle();
        mod_en      = mode;
        inp_device  = data;
        ctrl_dataIn = 1'b1;
        wait_cycle();
        ctrl_dataIn = 1'b0;
        edges = 0;
        while (!ctrl_dataOut)
        begin
            wait_cycle();
            edges++;
        end
        check_eq(128'(edges), 128'(LATENCY), "edges from strobe to ctrl_dataOut");
        result = outp_device;
    endtask

    task automatic check_reset_state();
        check_eq({127'd0, ctrl_dataOut}, 128'd0, "ctrl_dataOut after reset");
        check_eq({127'd0, busy}, 128'd0, "busy after reset");
        check_eq(outp_device, 128'd0, "outp_device after reset");
    endtask

    task automatic encrypt_known_answer();
        aes_pkg::block_t ct;
        run_block(aes_pkg::MODE_ENC, FIPS_PT, ct);
        check_eq(ct, FIPS_CT, "fips encryption");
    endtask

    task automatic decrypt_known_answer();
        aes_pkg::block_t pt;
        run_block(aes_pkg::MODE_DEC, FIPS_CT, pt);
        check_eq(pt, FIPS_PT, "fips decryption");
    endtask

    // second strobe lands mid-run and must vanish
    task automatic busy_strobe_dropped();
        aes_pkg::block_t spare;
        int edges;
        wait_idle();
        mod_en      = aes_pkg::MODE_ENC;
        inp_device  = FIPS_PT;
        ctrl_dataIn = 1'b1;
        wait_cycle();
        ctrl_dataIn = 1'b0;
        edges = 0;
        repeat (5)
        begin
            wait_cycle();
            edges++;
        end
        check_eq({127'd0, busy}, 128'd1, "busy during encryption");
        random_block(spare);
        inp_device  = spare;
        ctrl_dataIn = 1'b1;
        wait_cycle();
        edges++;
        ctrl_dataIn = 1'b0;
        while (!ctrl_dataOut)
        begin
            wait_cycle();
            edges++;
        end
        check_eq(128'(edges), 128'(LATENCY), "latency with a dropped strobe");
        check_eq(outp_device, FIPS_CT, "result with a dropped strobe");
        // no second result for the dropped block
        repeat (30)
        begin
            wait_cycle();
            check_eq({127'd0, ctrl_dataOut}, 128'd0, "extra ctrl_dataOut");
        end
    endtask

    // mode 3 is reserved
    task automatic reserved_mode_ignored();
        aes_pkg::block_t junk;
        wait_idle();
        random_block(junk);
        mod_en      = 2'd3;
        inp_device  = junk;
        ctrl_dataIn = 1'b1;
        wait_cycle();
        ctrl_dataIn = 1'b0;
        mod_en      = aes_pkg::MODE_ENC;
        check_eq({127'd0, busy}, 128'd0, "busy after reserved mode");
        repeat (30)
        begin
            wait_cycle();
            check_eq({127'd0, ctrl_dataOut}, 128'd0, "ctrl_dataOut after reserved mode");
            check_eq({127'd0, busy}, 128'd0, "busy after reserved mode");
        end
    endtask

    task automatic round_trip_random();
        aes_pkg::key_t   key;
        aes_pkg::block_t pt;
        aes_pkg::block_t ct;
        aes_pkg::block_t back;
        random_block(pt);
        key[255:128] = pt;
        random_block(pt);
        key[127:0] = pt;
        load_key(key);
        for (int i = 0; i < 20; i++)
        begin
            random_block(pt);
            run_block(aes_pkg::MODE_ENC, pt, ct);
            run_block(aes_pkg::MODE_DEC, ct, back);
            check_eq(back, pt, $sformatf("round trip block %0d", i));
        end
        // a new key load must overwrite every round key
        load_key(FIPS_KEY);
        encrypt_known_answer();
    endtask

    initial
    begin
        rng_state   = 32'd90;
        resetn      = 1'b0;
        inp_device  = '0;
        mod_en      = aes_pkg::MODE_ENC;
        ctrl_dataIn = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;

        check_reset_state();
        repeat (3) wait_cycle();
        check_reset_state();

        load_key(FIPS_KEY);
        encrypt_known_answer();
        decrypt_known_answer();
        busy_strobe_dropped();
        reserved_mode_ignored();
        round_trip_random();

        $display("No errors");
        $finish;
    end

endmodule

// ==== sim.f ====
aes_pkg.sv
aes_key_expand.sv
aes_round_key_store.sv
aes_encrypt_core.sv
aes_decrypt_core.sv
aes256_device.sv
tb_aes256_device.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_aes256_device -f sim.f -o tb_sim

out=$(./obj_dir/tb_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
